//--- design/ooo_params.svh
// build-time sizes for the execution back end
// queue depth, tag width and data path width
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// entries per issue queue and the starting credit
`define OOO_IQ_DEPTH 4

// destination tag width
`define OOO_TAG_W 6

// data path width and the divider iteration count
`define OOO_XLEN 32

`endif

//--- design/ooo_pkg.sv
// shared types for the execution back end
// data words, tags, credits, op encodings, queue entries
`include "ooo_params.svh"

package ooo_pkg;

	typedef logic [`OOO_XLEN-1:0] word_t;
	typedef logic [`OOO_TAG_W-1:0] tag_t;
	typedef logic [$clog2(`OOO_IQ_DEPTH + 1)-1:0] credit_t;

	typedef enum logic [1:0] {
		CLS_INT = 2'd0,
		CLS_MUL = 2'd1,
		CLS_DIV = 2'd2
	} op_class_e;

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		OR  = 4'd3,
		AND = 4'd4,
		BEQ = 4'd5,
		BNE = 4'd6,
		MUL = 4'd7,
		DIV = 4'd8
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		word_t   rs1;
		word_t   rs2;
		tag_t    tag;
	} issue_entry_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

endpackage

//--- design/exec_ifs.sv
// iq_if links an issue queue to its execution unit
// cdb_req_if links an execution unit to the CDB arbiter
`timescale 1ns/1ps

interface iq_if;
	logic                  valid;
	ooo_pkg::issue_entry_t entry;
	logic                  pop;

	modport queue (
		output valid,
		output entry,
		input  pop
	);

	modport unit (
		input  valid,
		input  entry,
		output pop
	);
endinterface

interface cdb_req_if;
	logic           req;
	ooo_pkg::tag_t  tag;
	ooo_pkg::word_t data;
	logic           is_branch;
	logic           taken;
	logic           gnt;

	modport unit (output req, output tag, output data, output is_branch, output taken, input gnt);
	modport arb (input req, input tag, input data, input is_branch, input taken, output gnt);
endinterface

//--- design/dispatch_router.sv
// dispatch router
// steers each operation to its class queue under credit flow control
`timescale 1ns/1ps
`include "ooo_params.svh"

module dispatch_router (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               disp_valid,
	input  ooo_pkg::op_class_e disp_class,
	output logic               disp_ready,
	output logic [2:0]         push,
	input  logic [2:0]         credit_ret
);

	ooo_pkg::credit_t credit [3];
	logic [2:0] cls_hot;
	logic [2:0] has_credit;

	always_comb begin
		case (disp_class)
			ooo_pkg::CLS_INT: cls_hot = 3'b001;
			ooo_pkg::CLS_MUL: cls_hot = 3'b010;
			ooo_pkg::CLS_DIV: cls_hot = 3'b100;
			default:          cls_hot = 3'b000;
		endcase
	end

	for (genvar g = 0; g < 3; g++) begin : g_credit
		assign has_credit[g] = (credit[g] != '0);

		// a wrapped counter also lands above the depth
		a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
			credit[g] <= ooo_pkg::credit_t'(`OOO_IQ_DEPTH));
	end

	// unknown class is never ready
	assign disp_ready = |(cls_hot & has_credit);
	assign push = {3{disp_valid && disp_ready}} & cls_hot;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++) begin
				credit[i] <= ooo_pkg::credit_t'(`OOO_IQ_DEPTH);
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				credit[i] <= credit[i] + ooo_pkg::credit_t'(credit_ret[i])
					- ooo_pkg::credit_t'(push[i]);
			end
		end
	end

endmodule

//--- design/issue_queue.sv
// issue queue
// circular FIFO of issue entries, one credit back per pop
`timescale 1ns/1ps
`include "ooo_params.svh"

module issue_queue (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  ooo_pkg::issue_entry_t push_entry,
	output logic                  credit_ret,
	iq_if.queue                   iq
);

	localparam int PTR_W = (`OOO_IQ_DEPTH > 1) ? $clog2(`OOO_IQ_DEPTH) : 1;

	ooo_pkg::issue_entry_t mem [`OOO_IQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	ooo_pkg::credit_t count;
	logic pop_fire;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`OOO_IQ_DEPTH - 1))
			return '0;
		return p + PTR_W'(1);
	endfunction

	assign pop_fire = iq.valid && iq.pop;
	assign credit_ret = pop_fire;
	assign iq.valid = (count != '0);
	assign iq.entry = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop_fire)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop_fire})
				2'b10:   count <= count + ooo_pkg::credit_t'(1);
				2'b01:   count <= count - ooo_pkg::credit_t'(1);
				default: count <= count;
			endcase
		end
	end

	// router credits must keep pushes off a full queue
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> count < ooo_pkg::credit_t'(`OOO_IQ_DEPTH));

endmodule

//--- design/int_alu_unit.sv
// integer unit
// single-cycle ALU and BEQ/BNE compare with a held result register
`timescale 1ns/1ps

module int_alu_unit (
	input  logic clk,
	input  logic rst_n,
	iq_if.unit   iq,
	cdb_req_if.unit cdb
);

	ooo_pkg::issue_entry_t e;
	ooo_pkg::word_t alu_res;
	logic is_br;
	logic br_taken;
	logic res_valid;

	assign e = iq.entry;
	// take a new op when the output slot frees up this cycle
	assign iq.pop = iq.valid && (!res_valid || cdb.gnt);

	always_comb begin
		alu_res  = '0;
		is_br    = 1'b0;
		br_taken = 1'b0;
		case (e.op)
			ooo_pkg::ADD: alu_res = e.rs1 + e.rs2;
			ooo_pkg::SUB: alu_res = e.rs1 - e.rs2;
			ooo_pkg::XOR: alu_res = e.rs1 ^ e.rs2;
			ooo_pkg::OR:  alu_res = e.rs1 | e.rs2;
			ooo_pkg::AND: alu_res = e.rs1 & e.rs2;
			ooo_pkg::BEQ: begin
				is_br    = 1'b1;
				br_taken = (e.rs1 == e.rs2);
			end
			ooo_pkg::BNE: begin
				is_br    = 1'b1;
				br_taken = (e.rs1 != e.rs2);
			end
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else if (iq.pop)
			res_valid <= 1'b1;
		else if (cdb.gnt)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (iq.pop) begin
			cdb.tag       <= e.tag;
			cdb.data      <= alu_res;
			cdb.is_branch <= is_br;
			cdb.taken     <= br_taken;
		end
	end

	assign cdb.req = res_valid;

	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.req && !cdb.gnt |=>
			cdb.req && $stable({cdb.tag, cdb.data, cdb.is_branch, cdb.taken}));

endmodule

//--- design/mult_unit.sv
// multiply unit
// three-stage pipeline, low XLEN bits of the product, whole-pipe stall
`timescale 1ns/1ps
`include "ooo_params.svh"

module mult_unit (
	input  logic clk,
	input  logic rst_n,
	iq_if.unit   iq,
	cdb_req_if.unit cdb
);

	localparam int H = `OOO_XLEN / 2;

	logic s1_v;
	logic s2_v;
	logic s3_v;
	logic adv;
	ooo_pkg::word_t s1_a;
	ooo_pkg::word_t s1_b;
	ooo_pkg::word_t s2_lo;
	ooo_pkg::word_t s2_hi;
	ooo_pkg::tag_t s1_tag;
	ooo_pkg::tag_t s2_tag;

	// everything moves only when the last stage is empty or granted
	assign adv = !s3_v || cdb.gnt;
	assign iq.pop = iq.valid && adv;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_v <= 1'b0;
			s2_v <= 1'b0;
			s3_v <= 1'b0;
		end else if (adv) begin
			s1_v <= iq.pop;
			s2_v <= s1_v;
			s3_v <= s2_v;
		end
	end

	always_ff @(posedge clk) begin
		if (adv) begin
			s1_a   <= iq.entry.rs1;
			s1_b   <= iq.entry.rs2;
			s1_tag <= iq.entry.tag;
			// partial products on the two halves of b
			s2_lo  <= s1_a * ooo_pkg::word_t'(s1_b[H-1:0]);
			s2_hi  <= s1_a * ooo_pkg::word_t'(s1_b[`OOO_XLEN-1:H]);
			s2_tag <= s1_tag;
			cdb.data <= s2_lo + (s2_hi << H);
			cdb.tag  <= s2_tag;
		end
	end

	assign cdb.req = s3_v;
	assign cdb.is_branch = 1'b0;
	assign cdb.taken = 1'b0;

	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.req && !cdb.gnt |=> cdb.req && $stable({cdb.tag, cdb.data}));

endmodule

//--- design/div_unit.sv
// divide unit
// restoring unsigned divider, one quotient bit per cycle
`timescale 1ns/1ps
`include "ooo_params.svh"

module div_unit (
	input  logic clk,
	input  logic rst_n,
	iq_if.unit   iq,
	cdb_req_if.unit cdb
);

	localparam int CNT_W = $clog2(`OOO_XLEN);

	ooo_pkg::div_state_e state;
	logic [CNT_W-1:0] cnt;
	ooo_pkg::word_t dvsr;
	ooo_pkg::word_t quo;
	ooo_pkg::word_t rem;
	ooo_pkg::tag_t tag;
	logic [`OOO_XLEN:0] rem_shift;
	logic [`OOO_XLEN:0] rem_sub;
	logic take;

	// quo starts as the dividend and fills with quotient bits from the right
	assign rem_shift = {rem, quo[`OOO_XLEN-1]};
	assign rem_sub = rem_shift - {1'b0, dvsr};
	// zero divisor always subtracts, so the quotient comes out all ones
	assign take = (rem_shift >= {1'b0, dvsr});

	assign iq.pop = iq.valid && (state == ooo_pkg::DIV_IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ooo_pkg::DIV_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				ooo_pkg::DIV_IDLE: begin
					cnt <= '0;
					if (iq.pop)
						state <= ooo_pkg::DIV_RUN;
				end
				ooo_pkg::DIV_RUN: begin
					cnt <= cnt + CNT_W'(1);
					if (cnt == CNT_W'(`OOO_XLEN - 1))
						state <= ooo_pkg::DIV_DONE;
				end
				ooo_pkg::DIV_DONE: begin
					if (cdb.gnt)
						state <= ooo_pkg::DIV_IDLE;
				end
				default: state <= ooo_pkg::DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (iq.pop) begin
			quo  <= iq.entry.rs1;
			dvsr <= iq.entry.rs2;
			tag  <= iq.entry.tag;
			rem  <= '0;
		end else if (state == ooo_pkg::DIV_RUN) begin
			rem <= take ? rem_sub[`OOO_XLEN-1:0] : rem_shift[`OOO_XLEN-1:0];
			quo <= {quo[`OOO_XLEN-2:0], take};
		end
	end

	assign cdb.req = (state == ooo_pkg::DIV_DONE);
	assign cdb.tag = tag;
	assign cdb.data = quo;
	assign cdb.is_branch = 1'b0;
	assign cdb.taken = 1'b0;

	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.req && !cdb.gnt |=> cdb.req && $stable({cdb.tag, cdb.data}));

endmodule

//--- design/cdb_arbiter.sv
// CDB arbiter
// round-robin grant over three units, registered bus output
`timescale 1ns/1ps

module cdb_arbiter (
	input  logic           clk,
	input  logic           rst_n,
	cdb_req_if.arb         req_int,
	cdb_req_if.arb         req_mul,
	cdb_req_if.arb         req_div,
	output logic           cdb_valid,
	output ooo_pkg::tag_t  cdb_tag,
	output ooo_pkg::word_t cdb_data,
	output logic           cdb_branch,
	output logic           cdb_taken
);

	logic [2:0] req;
	logic [2:0] gnt;
	logic [1:0] last;

	assign req = {req_div.req, req_mul.req, req_int.req};
	assign req_int.gnt = gnt[0];
	assign req_mul.gnt = gnt[1];
	assign req_div.gnt = gnt[2];

	// search starts one past the previous winner
	always_comb begin
		gnt = '0;
		for (int k = 1; k <= 3; k++) begin
			if (gnt == '0 && req[(int'(last) + k) % 3])
				gnt[(int'(last) + k) % 3] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cdb_valid <= 1'b0;
			last      <= 2'd2;
		end else begin
			cdb_valid <= |gnt;
			if (gnt[0])
				last <= 2'd0;
			else if (gnt[1])
				last <= 2'd1;
			else if (gnt[2])
				last <= 2'd2;
		end
	end

	always_ff @(posedge clk) begin
		if (gnt[0]) begin
			cdb_tag    <= req_int.tag;
			cdb_data   <= req_int.data;
			cdb_branch <= req_int.is_branch;
			cdb_taken  <= req_int.taken;
		end else if (gnt[1]) begin
			cdb_tag    <= req_mul.tag;
			cdb_data   <= req_mul.data;
			cdb_branch <= req_mul.is_branch;
			cdb_taken  <= req_mul.taken;
		end else if (gnt[2]) begin
			cdb_tag    <= req_div.tag;
			cdb_data   <= req_div.data;
			cdb_branch <= req_div.is_branch;
			cdb_taken  <= req_div.taken;
		end
	end

	a_gnt_legal: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

//--- design/ooo_exec_top.sv
// execution back end top level
// router, three issue queues, int/mul/div units and the CDB arbiter
`timescale 1ns/1ps

module ooo_exec_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               disp_valid,
	input  ooo_pkg::op_class_e disp_class,
	input  ooo_pkg::alu_op_e   disp_op,
	input  ooo_pkg::word_t     disp_rs1,
	input  ooo_pkg::word_t     disp_rs2,
	input  ooo_pkg::tag_t      disp_tag,
	output logic               disp_ready,
	output logic               cdb_valid,
	output ooo_pkg::tag_t      cdb_tag,
	output ooo_pkg::word_t     cdb_data,
	output logic               cdb_branch,
	output logic               cdb_taken
);

	logic [2:0] push;
	logic [2:0] credit_ret;
	ooo_pkg::issue_entry_t disp_entry;

	iq_if iq_int ();
	iq_if iq_mul ();
	iq_if iq_div ();
	cdb_req_if cdb_int ();
	cdb_req_if cdb_mul ();
	cdb_req_if cdb_div ();

	assign disp_entry = '{op: disp_op, rs1: disp_rs1, rs2: disp_rs2, tag: disp_tag};

	dispatch_router u_router (
		.clk        (clk),
		.rst_n      (rst_n),
		.disp_valid (disp_valid),
		.disp_class (disp_class),
		.disp_ready (disp_ready),
		.push       (push),
		.credit_ret (credit_ret)
	);

	// queue index follows the class encoding
	issue_queue u_iq_int (.clk(clk), .rst_n(rst_n), .push(push[0]), .push_entry(disp_entry),
		.credit_ret(credit_ret[0]), .iq(iq_int));
	issue_queue u_iq_mul (.clk(clk), .rst_n(rst_n), .push(push[1]), .push_entry(disp_entry),
		.credit_ret(credit_ret[1]), .iq(iq_mul));
	issue_queue u_iq_div (.clk(clk), .rst_n(rst_n), .push(push[2]), .push_entry(disp_entry),
		.credit_ret(credit_ret[2]), .iq(iq_div));

	int_alu_unit u_int (.clk(clk), .rst_n(rst_n), .iq(iq_int), .cdb(cdb_int));
	mult_unit    u_mul (.clk(clk), .rst_n(rst_n), .iq(iq_mul), .cdb(cdb_mul));
	div_unit     u_div (.clk(clk), .rst_n(rst_n), .iq(iq_div), .cdb(cdb_div));

	cdb_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_int    (cdb_int),
		.req_mul    (cdb_mul),
		.req_div    (cdb_div),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data),
		.cdb_branch (cdb_branch),
		.cdb_taken  (cdb_taken)
	);

endmodule

//--- bench/ooo_exec_tb.sv
// testbench for the execution back end
// reads operations and expected CDB results from the stimulus file
// checks every tag once on the CDB and the divide back-pressure
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_exec_tb;

	localparam int N_TAGS = 1 << `OOO_TAG_W;
	localparam int MAX_OPS = 64;
	localparam int READY_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int DIV_LIMIT = `OOO_IQ_DEPTH + 1;

	logic clk;
	logic rst_n;
	logic disp_valid;
	ooo_pkg::op_class_e disp_class;
	ooo_pkg::alu_op_e disp_op;
	ooo_pkg::word_t disp_rs1;
	ooo_pkg::word_t disp_rs2;
	ooo_pkg::tag_t disp_tag;
	logic disp_ready;
	logic cdb_valid;
	ooo_pkg::tag_t cdb_tag;
	ooo_pkg::word_t cdb_data;
	logic cdb_branch;
	logic cdb_taken;

	// operations in file order
	ooo_pkg::op_class_e op_class [MAX_OPS];
	ooo_pkg::alu_op_e op_code [MAX_OPS];
	ooo_pkg::word_t op_rs1 [MAX_OPS];
	ooo_pkg::word_t op_rs2 [MAX_OPS];
	ooo_pkg::tag_t op_tag [MAX_OPS];
	int n_ops;

	// expected results indexed by tag
	ooo_pkg::word_t exp_data [N_TAGS];
	logic exp_taken [N_TAGS];
	logic exp_branch [N_TAGS];
	logic tag_is_div [N_TAGS];
	logic in_file [N_TAGS];
	logic dispatched [N_TAGS];
	logic seen [N_TAGS];

	int seen_count = 0;
	int div_out = 0;
	logic first_accepted = 1'b0;
	logic div_stall_seen = 1'b0;
	logic int_during_stall = 1'b0;

	ooo_exec_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.disp_valid (disp_valid),
		.disp_class (disp_class),
		.disp_op    (disp_op),
		.disp_rs1   (disp_rs1),
		.disp_rs2   (disp_rs2),
		.disp_tag   (disp_tag),
		.disp_ready (disp_ready),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data),
		.cdb_branch (cdb_branch),
		.cdb_taken  (cdb_taken)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input ooo_pkg::tag_t tag, input ooo_pkg::word_t got,
		input ooo_pkg::word_t exp);
		if (got !== exp)
			stop_run($sformatf("ERR cdb_data tag 0x%h: got 0x%h, expected 0x%h", tag, got, exp));
	endtask

	task automatic check_branch(input ooo_pkg::tag_t tag, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("ERR cdb_taken tag 0x%h: got 0x%h, expected 0x%h", tag, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("ERR %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic load_stimulus();
		int fd;
		int n;
		string line;
		logic [31:0] f_cls;
		logic [31:0] f_op;
		logic [31:0] f_rs1;
		logic [31:0] f_rs2;
		logic [31:0] f_tag;
		logic [31:0] f_data;
		logic [31:0] f_taken;
		for (int t = 0; t < N_TAGS; t++) begin
			in_file[t] = 1'b0;
			dispatched[t] = 1'b0;
			seen[t] = 1'b0;
		end
		n_ops = 0;
		fd = $fopen("bench/ooo_exec_stimulus.txt", "r");
		if (fd == 0)
			stop_run("cannot open the stimulus file bench/ooo_exec_stimulus.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h",
				f_cls, f_op, f_rs1, f_rs2, f_tag, f_data, f_taken);
			if (n <= 0)
				continue;
			if (n != 7)
				stop_run($sformatf("malformed stimulus line: %s", line));
			if (f_tag >= N_TAGS || in_file[f_tag])
				stop_run($sformatf("tag 0x%h in the stimulus file is out of range or repeated",
					f_tag));
			if (n_ops >= MAX_OPS)
				stop_run("too many operations in the stimulus file");
			op_class[n_ops] = ooo_pkg::op_class_e'(f_cls[1:0]);
			op_code[n_ops] = ooo_pkg::alu_op_e'(f_op[3:0]);
			op_rs1[n_ops] = f_rs1;
			op_rs2[n_ops] = f_rs2;
			op_tag[n_ops] = ooo_pkg::tag_t'(f_tag);
			in_file[f_tag] = 1'b1;
			exp_data[f_tag] = f_data;
			exp_taken[f_tag] = f_taken[0];
			// only the compares report on the branch flag
			exp_branch[f_tag] = (f_op[3:0] == 4'(ooo_pkg::BEQ))
				|| (f_op[3:0] == 4'(ooo_pkg::BNE));
			tag_is_div[f_tag] = (f_cls[1:0] == 2'(ooo_pkg::CLS_DIV));
			n_ops++;
		end
		$fclose(fd);
	endtask

	task automatic dispatch_op(input int i);
		int waited;
		@(posedge clk);
		#1;
		disp_valid = 1'b1;
		disp_class = op_class[i];
		disp_op = op_code[i];
		disp_rs1 = op_rs1[i];
		disp_rs2 = op_rs2[i];
		disp_tag = op_tag[i];
		dispatched[op_tag[i]] = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!disp_ready) begin
			if (op_class[i] == ooo_pkg::CLS_DIV)
				div_stall_seen = 1'b1;
			waited++;
			if (waited > READY_TIMEOUT)
				stop_run($sformatf("timeout waiting for disp_ready on tag 0x%h", op_tag[i]));
			@(negedge clk);
		end
		// ready cannot change before the accepting edge
		@(posedge clk);
		#1;
		disp_valid = 1'b0;
		first_accepted = 1'b1;
		if (op_class[i] == ooo_pkg::CLS_DIV) begin
			div_out++;
			if (div_out > DIV_LIMIT)
				stop_run($sformatf("%0d divides accepted at once, more than the queue allows",
					div_out));
		end else if (op_class[i] == ooo_pkg::CLS_INT && div_out == DIV_LIMIT) begin
			int_during_stall = 1'b1;
		end
	endtask

	// CDB monitor sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && !first_accepted) begin
			check_flag("cdb_valid", cdb_valid, 1'b0);
			check_flag("disp_ready", disp_ready, 1'b1);
		end
		if (rst_n && cdb_valid) begin
			if (!dispatched[cdb_tag])
				stop_run($sformatf("CDB returned tag 0x%h that was never dispatched", cdb_tag));
			if (seen[cdb_tag])
				stop_run($sformatf("CDB returned tag 0x%h a second time", cdb_tag));
			check_data(cdb_tag, cdb_data, exp_data[cdb_tag]);
			check_flag("cdb_branch", cdb_branch, exp_branch[cdb_tag]);
			check_branch(cdb_tag, cdb_taken, exp_taken[cdb_tag]);
			seen[cdb_tag] = 1'b1;
			seen_count++;
			if (tag_is_div[cdb_tag])
				div_out--;
		end
	end

	initial begin
		int seed_ret;
		int gap;
		int waited;
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp_class = ooo_pkg::CLS_INT;
		disp_op = ooo_pkg::ADD;
		disp_rs1 = '0;
		disp_rs2 = '0;
		disp_tag = '0;
		seed_ret = $urandom(32'hd76f_dc6d);
		load_stimulus();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// quiet window before the first dispatch
		repeat (4) @(posedge clk);
		for (int i = 0; i < n_ops; i++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) @(posedge clk);
			dispatch_op(i);
		end
		waited = 0;
		while (seen_count < n_ops) begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_TIMEOUT)
				stop_run($sformatf("timeout with %0d of %0d results seen", seen_count, n_ops));
		end
		if (div_stall_seen && int_during_stall) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stop_run("divide queue never filled while integer ops were still accepted");
		end
	end

endmodule

//--- bench/ooo_exec_stimulus.txt
# class op rs1 rs2 tag exp_data exp_taken, all hex
# class 0 int 1 mul 2 div; op 0 add 1 sub 2 xor 3 or 4 and 5 beq 6 bne 7 mul 8 div
0 0 00000005 00000007 01 0000000c 0
0 1 00000003 00000005 02 fffffffe 0
0 2 f0f0f0f0 0ff00ff0 03 ff00ff00 0
0 3 12340000 00005678 04 12345678 0
0 4 ffff0000 12345678 05 12340000 0
0 5 0000abcd 0000abcd 06 00000000 1
0 5 0000abcd 0000abce 07 00000000 0
0 6 00000001 00000002 08 00000000 1
1 7 00000007 00000006 09 0000002a 0
1 7 ffffffff ffffffff 0a 00000001 0
1 7 12345678 00010000 0b 56780000 0
1 7 00010001 00010001 0c 00020001 0
2 8 00000064 00000007 0d 0000000e 0
2 8 12345678 00000000 0e ffffffff 0
2 8 ffffffff 00000001 0f ffffffff 0
2 8 ffffffff ffffffff 10 00000001 0
2 8 00000007 00000009 11 00000000 0
2 8 80000000 00000010 12 08000000 0
2 8 000003e8 0000000a 13 00000064 0
2 8 deadbeef 00010000 14 0000dead 0
0 0 ffffffff 00000001 15 00000000 0
0 6 00000009 00000009 16 00000000 0
0 1 00000000 00000001 17 ffffffff 0
1 7 00000003 fffffffd 18 fffffff7 0
0 2 aaaaaaaa 55555555 19 ffffffff 0

//--- list.f
+incdir+design
design/ooo_pkg.sv
design/exec_ifs.sv
design/dispatch_router.sv
design/issue_queue.sv
design/int_alu_unit.sv
design/mult_unit.sv
design/div_unit.sv
design/cdb_arbiter.sv
design/ooo_exec_top.sv
bench/ooo_exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execution back end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module ooo_exec_tb -o sim_ooo_exec
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_ooo_exec
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

exit 0
